/* Makefile */
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module fb_tb -f filelist.f -o fb_sim
	./obj_dir/fb_sim > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* dv/fb_tb.sv */
// ------------------------------------------------
// Testbench for the VGA framebuffer that loads pixel writes
// and screen samples from the vectors file, checks the raster
// timing on every cycle and the image for each rotation
// ------------------------------------------------

`timescale 1ns/1ns

module fb_tb import vga_timing_pkg::*, frame_pkg::*; ();

    logic    clk_vga;
    logic    reset;
    logic    px_valid;
    logic    px_ready;
    coord_t  px_x;
    coord_t  px_y;
    pixel_t  px_data;
    rotate_e rotate;
    pixel_t  rgb_out;
    logic    hsync_out, vsync_out, blank_out, odd_line_out;

    // Records from the vectors file where W uses a, b and d and C uses all four
    byte    rec_kind [$];
    int     rec_a [$];                  // Pixel x or rotation
    int     rec_b [$];                  // Pixel y or screen column
    int     rec_c [$];                  // Screen line
    int     rec_d [$];                  // Pixel data or expected rgb

    // Screen samples for the frame being scanned
    int     samp_col [$];
    int     samp_line [$];
    pixel_t samp_exp [$];
    bit     samp_hit [$];

    // Monitor state is updated once per clock on the falling edge
    int     cyc = 0;                    // Cycles since reset release
    int     hcyc = 0;
    int     hlow = 0;
    int     vlow = 0;
    int     blow = 0;
    int     col = 0;
    int     line = -1;                  // Visible line that stays at -1 until the first blank_out fall
    bit     hs_seen = 1'b0;
    bit     ready_seen = 1'b0;
    bit     armed = 1'b0;               // Samples are compared only while set
    bit     vs_rise = 1'b0;
    bit     bl_fall = 1'b0;
    logic   prev_hs, prev_vs, prev_bl;

    fb_top fb_top_inst (
        .clk_vga      (clk_vga),
        .reset        (reset),
        .px_valid     (px_valid),
        .px_ready     (px_ready),
        .px_x         (px_x),
        .px_y         (px_y),
        .px_data      (px_data),
        .rotate       (rotate),
        .rgb_out      (rgb_out),
        .hsync_out    (hsync_out),
        .vsync_out    (vsync_out),
        .blank_out    (blank_out),
        .odd_line_out (odd_line_out)
    );

    always #5 clk_vga = ~clk_vga;       // 10 ns period

    // ------------------------------------------------
    // Error handling and compare tasks
    // ------------------------------------------------
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // ------------------------------------------------
    // One clock of monitoring for timing, position and samples
    // ------------------------------------------------
    task automatic step_clock();
        bit hs_fall;
        bit hs_rise;
        bit bl_rise;
        @(negedge clk_vga);
        cyc++;
        hs_fall = prev_hs && !hsync_out;
        hs_rise = !prev_hs && hsync_out;
        vs_rise = !prev_vs && vsync_out;
        bl_fall = prev_bl && !blank_out;
        bl_rise = !prev_bl && blank_out;
        prev_hs = hsync_out;
        prev_vs = vsync_out;
        prev_bl = blank_out;

        if (hs_fall) begin
            if (hs_seen) check_count("hsync_out period", hcyc, H_TOTAL);  // Fall to fall is one line
            hs_seen = 1'b1;
            hcyc    = 0;
        end
        hcyc++;
        if (hs_rise) begin
            check_count("hsync_out low cycles", hlow, H_SYNC_END - H_SYNC_START);
            hlow = 0;
        end
        if (!hsync_out) hlow++;
        if (vs_rise) begin
            check_count("vsync_out low cycles", vlow, (V_SYNC_END - V_SYNC_START) * H_TOTAL);
            vlow = 0;
        end
        if (!vsync_out) vlow++;
        if (bl_rise) begin
            check_count("blank_out low cycles", blow, H_ACTIVE);
            blow = 0;
        end
        if (!blank_out) blow++;

        // Ready must wait until the counters have covered all visible lines
        if (px_ready && !ready_seen) begin
            check_count("cycles to first px_ready", cyc, V_ACTIVE * H_TOTAL);
            ready_seen = 1'b1;
        end

        if (vs_rise) line = -1;            // Next visible line is line 0
        if (bl_fall) begin
            line++;
            col = 0;
            check_bit("odd_line_out", odd_line_out, line[0]);
        end
        if (blank_out) begin
            check_pixel("rgb_out in blanking", rgb_out, '0);
        end else begin
            if (armed) begin
                foreach (samp_col[i]) begin
                    if (samp_col[i] == col && samp_line[i] == line) begin
                        check_pixel($sformatf("rgb_out at column %0d line %0d", col, line),
                                    rgb_out, samp_exp[i]);
                        samp_hit[i] = 1'b1;
                    end
                end
            end
            col++;
        end
    endtask

    // ------------------------------------------------
    // Waits with a cycle limit of their own
    // ------------------------------------------------
    task automatic wait_vsync_rise();
        int n;
        n = 0;
        step_clock();
        while (!vs_rise) begin
            n++;
            if (n > 1000000) abort_run("Timeout: no rising edge on vsync_out");
            step_clock();
        end
    endtask

    task automatic wait_blank_fall();
        int n;
        n = 0;
        step_clock();
        while (!bl_fall) begin
            n++;
            if (n > 1000000) abort_run("Timeout: no visible line started on blank_out");
            step_clock();
        end
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!px_ready) begin
            n++;
            if (n > 500000) abort_run("Timeout: px_ready never went high");
            step_clock();
        end
    endtask

    // ------------------------------------------------
    // Stimulus
    // ------------------------------------------------
    task automatic write_pixel(input int x, input int y, input int data);
        wait_ready();
        px_x     = coord_t'(x);
        px_y     = coord_t'(y);
        px_data  = pixel_t'(data);
        px_valid = 1'b1;
        step_clock();                      // Accepted on the rising edge in between
        px_valid = 1'b0;
    endtask

    task automatic change_rotation(input int r);
        wait_blank_fall();                 // Change while lines are being drawn
        rotate = rotate_e'(r);
        wait_vsync_rise();                 // New value is latched at the coming frame wrap
    endtask

    task automatic scan_frame();
        wait_vsync_rise();
        armed = 1'b1;
        wait_vsync_rise();                 // All 480 visible lines pass in between
        armed = 1'b0;
        foreach (samp_hit[i]) begin
            if (!samp_hit[i]) begin
                abort_run($sformatf("Screen position column %0d line %0d was never displayed",
                                    samp_col[i], samp_line[i]));
            end
        end
    endtask

    task automatic load_vectors();
        int               fd;
        int               code;
        byte              kind;
        int               a;
        int               b;
        int               c;
        int               d;
        logic [8*120-1:0] skip_text;
        fd = $fopen("dv/fb_vectors.txt", "r");
        if (fd == 0) abort_run("Cannot open the vectors file dv/fb_vectors.txt");
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", kind);
            if (code == 1) begin
                if (kind == "#") begin
                    code = $fgets(skip_text, fd);
                end else if (kind == "W") begin
                    code = $fscanf(fd, "%d %d %h", a, b, d);
                    if (code != 3) abort_run("Malformed pixel write in the vectors file");
                    c = 0;
                end else if (kind == "C") begin
                    code = $fscanf(fd, "%d %d %d %h", a, b, c, d);
                    if (code != 4) abort_run("Malformed screen sample in the vectors file");
                end else begin
                    abort_run($sformatf("Unknown record type %c in the vectors file", kind));
                end
                if (kind != "#") begin
                    rec_kind.push_back(kind);
                    rec_a.push_back(a);
                    rec_b.push_back(b);
                    rec_c.push_back(c);
                    rec_d.push_back(d);
                end
            end
        end
        $fclose(fd);
    endtask

    // ------------------------------------------------
    // Main sequence
    // ------------------------------------------------
    initial begin
        int i;
        int r;
        clk_vga  = 1'b0;
        reset    = 1'b1;
        px_valid = 1'b0;
        px_x     = '0;
        px_y     = '0;
        px_data  = '0;
        rotate   = ROT_0;
        load_vectors();
        repeat (2) @(negedge clk_vga);     // Two rising edges under reset
        reset = 1'b0;

        // Idle levels straight out of reset
        check_bit("hsync_out", hsync_out, 1'b1);
        check_bit("vsync_out", vsync_out, 1'b1);
        check_bit("blank_out", blank_out, 1'b1);
        check_pixel("rgb_out", rgb_out, '0);
        check_bit("px_ready", px_ready, 1'b0);
        prev_hs = hsync_out;
        prev_vs = vsync_out;
        prev_bl = blank_out;

        i = 0;
        while (i < rec_kind.size()) begin
            if (rec_kind[i] == "W") begin
                write_pixel(rec_a[i], rec_b[i], rec_d[i]);
                i++;
            end else begin
                // A run of samples with the same rotation is checked in one frame
                r = rec_a[i];
                samp_col.delete();
                samp_line.delete();
                samp_exp.delete();
                samp_hit.delete();
                while (i < rec_kind.size() && rec_kind[i] == "C" && rec_a[i] == r) begin
                    samp_col.push_back(rec_b[i]);
                    samp_line.push_back(rec_c[i]);
                    samp_exp.push_back(pixel_t'(rec_d[i]));
                    samp_hit.push_back(1'b0);
                    i++;
                end
                if (rotate_e'(r) != rotate) change_rotation(r);
                scan_frame();
            end
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* dv/fb_vectors.txt */
# W x y data: pixel write, x and y decimal, data hex
# C rotation column line rgb: expected rgb_out (hex) at a visible screen position
W 0 0 11
W 7 0 22
W 0 5 33
W 7 5 44
W 3 2 5a
W 0 1 77
# Off-image writes, x=8 would alias address 8 which is pixel (0,1)
W 8 0 ff
W 2 6 ee
# ROT_0, landscape window at column 312 line 234
C 0 312 234 11
C 0 313 235 11
C 0 327 234 22
C 0 312 245 33
C 0 327 245 44
C 0 318 238 5a
C 0 312 236 77
C 0 311 234 00
C 0 328 234 00
C 0 312 233 00
C 0 312 246 00
# ROT_90_CW, portrait window at column 314 line 232
C 1 324 232 11
C 1 325 247 22
C 1 314 232 33
C 1 314 246 44
C 1 320 238 5a
C 1 322 232 77
C 1 313 240 00
C 1 326 240 00
C 1 320 231 00
C 1 320 248 00
# ROT_180, landscape window
C 2 326 244 11
C 2 312 244 22
C 2 327 235 33
C 2 312 234 44
C 2 320 240 5a
C 2 326 242 77
C 2 311 240 00
# ROT_90_CCW, portrait window
C 3 314 246 11
C 3 314 232 22
C 3 325 247 33
C 3 324 232 44
C 3 318 240 5a
C 3 316 246 77
C 3 326 232 00

/* filelist.f */
hw/vga_timing_pkg.sv
hw/frame_pkg.sv
hw/raster_if.sv
hw/raster_decode.sv
hw/pixel_execute.sv
hw/pixel_store.sv
hw/video_result.sv
hw/fb_top.sv
dv/fb_tb.sv

/* hw/fb_top.sv */
// ------------------------------------------------
// VGA framebuffer top level: pixel write port in, a
// 640x480@60 stream out with the image centred and doubled
// Pipeline: decode, execute, store, result (4 clocks)
// ------------------------------------------------

`timescale 1ns/1ns

module fb_top import frame_pkg::*; (
    input  logic    clk_vga,
    input  logic    reset,
    // Pixel write port
    input  logic    px_valid,
    output logic    px_ready,
    input  coord_t  px_x,
    input  coord_t  px_y,
    input  pixel_t  px_data,
    // Orientation, picked up at the next frame boundary
    input  rotate_e rotate,
    // Video out
    output pixel_t  rgb_out,
    output logic    hsync_out,
    output logic    vsync_out,
    output logic    blank_out,
    output logic    odd_line_out
);

    fb_addr_t rd_addr;
    pixel_t   rd_data;

    raster_if ras_dec ();           // Decode to execute
    raster_if ras_exe ();           // Execute to result, aligned with rd_data

    raster_decode raster_decode_inst (
        .clk_vga  (clk_vga),
        .reset    (reset),
        .rotate   (rotate),
        .px_ready (px_ready),
        .ras      (ras_dec.source)
    );

    pixel_execute pixel_execute_inst (
        .clk_vga (clk_vga),
        .reset   (reset),
        .ras_in  (ras_dec.stage),
        .ras_out (ras_exe.source),
        .rd_addr (rd_addr)
    );

    pixel_store pixel_store_inst (
        .clk_vga  (clk_vga),
        .px_valid (px_valid),
        .px_ready (px_ready),
        .px_x     (px_x),
        .px_y     (px_y),
        .px_data  (px_data),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    video_result video_result_inst (
        .clk_vga      (clk_vga),
        .reset        (reset),
        .ras          (ras_exe.sink),
        .rd_data      (rd_data),
        .rgb_out      (rgb_out),
        .hsync_out    (hsync_out),
        .vsync_out    (vsync_out),
        .blank_out    (blank_out),
        .odd_line_out (odd_line_out)
    );

endmodule

/* hw/frame_pkg.sv */
// ------------------------------------------------
// Stored image geometry, pixel and address types, and the
// placement of the doubled image on the 640x480 screen
// ------------------------------------------------

package frame_pkg;
    import vga_timing_pkg::*;

    localparam int FRAME_W = 8;                        // Stored image width in pixels
    localparam int FRAME_H = 6;                        // Stored image height in pixels
    localparam int SCALE   = 2;                        // Each stored pixel becomes SCALE x SCALE
    localparam int PIXEL_W = 8;                        // Bits per pixel

    localparam int FB_DEPTH  = FRAME_W * FRAME_H;      // Entries in the frame memory
    localparam int FB_ADDR_W = $clog2(FB_DEPTH);

    typedef logic [PIXEL_W-1:0]   pixel_t;
    typedef logic [FB_ADDR_W-1:0] fb_addr_t;
    typedef logic [5:0]           coord_t;             // Image coordinate, also window u/v

    // Rotation opcode, the encoding matches the rotate input pins
    typedef enum logic [1:0] {
        ROT_0      = 2'd0,
        ROT_90_CW  = 2'd1,
        ROT_180    = 2'd2,
        ROT_90_CCW = 2'd3
    } rotate_e;

    // ------------------------------------------------
    // Window size and origin on screen
    // ------------------------------------------------
    // Landscape covers ROT_0 and ROT_180, portrait the two quarter turns
    localparam int WIN_W_LAND  = FRAME_W * SCALE;
    localparam int WIN_H_LAND  = FRAME_H * SCALE;
    localparam int WIN_W_PORT  = FRAME_H * SCALE;
    localparam int WIN_H_PORT  = FRAME_W * SCALE;
    localparam int WIN_X0_LAND = (H_ACTIVE - WIN_W_LAND) / 2;
    localparam int WIN_Y0_LAND = (V_ACTIVE - WIN_H_LAND) / 2;
    localparam int WIN_X0_PORT = (H_ACTIVE - WIN_W_PORT) / 2;
    localparam int WIN_Y0_PORT = (V_ACTIVE - WIN_H_PORT) / 2;

endpackage

/* hw/pixel_execute.sv */
// ------------------------------------------------
// Maps a window coordinate to a stored pixel for the
// current rotation and issues the memory read address
// The raster controls follow two cycles behind
// ------------------------------------------------

`timescale 1ns/1ns

module pixel_execute import frame_pkg::*; (
    input  logic     clk_vga,
    input  logic     reset,
    raster_if.stage  ras_in,    // Position straight from the counters
    raster_if.source ras_out,   // Same position, lined up with the read data
    output fb_addr_t rd_addr
);

    coord_t  img_x;
    coord_t  img_y;

    // First delay stage runs in step with rd_addr
    logic    in_window_d1;
    logic    blank_d1;
    logic    hsync_d1;
    logic    vsync_d1;
    logic    odd_line_d1;

    // ------------------------------------------------
    // Rotation mapping
    // ------------------------------------------------
    always_comb begin
        unique case (ras_in.rot)
            ROT_0: begin
                img_x = ras_in.win_u;
                img_y = ras_in.win_v;
            end
            ROT_90_CW: begin
                img_x = ras_in.win_v;
                img_y = coord_t'(FRAME_H - 1) - ras_in.win_u;   // Leftmost screen column is the bottom row
            end
            ROT_180: begin
                img_x = coord_t'(FRAME_W - 1) - ras_in.win_u;
                img_y = coord_t'(FRAME_H - 1) - ras_in.win_v;
            end
            ROT_90_CCW: begin
                img_x = coord_t'(FRAME_W - 1) - ras_in.win_v;   // Top screen row is the right column
                img_y = ras_in.win_u;
            end
        endcase
    end

    // Row-major address that the memory answers one cycle later
    always_ff @(posedge clk_vga) begin
        rd_addr <= fb_addr_t'(img_y * FRAME_W + img_x);
    end

    // ------------------------------------------------
    // Control delay of two stages to meet the read data
    // ------------------------------------------------
    always_ff @(posedge clk_vga) begin
        if (reset) begin
            in_window_d1      <= 1'b0;
            blank_d1          <= 1'b1;
            hsync_d1          <= 1'b1;
            vsync_d1          <= 1'b1;
            odd_line_d1       <= 1'b0;
            ras_out.in_window <= 1'b0;
            ras_out.blank     <= 1'b1;
            ras_out.hsync     <= 1'b1;
            ras_out.vsync     <= 1'b1;
            ras_out.odd_line  <= 1'b0;
        end else begin
            in_window_d1      <= ras_in.in_window;
            blank_d1          <= ras_in.blank;
            hsync_d1          <= ras_in.hsync;
            vsync_d1          <= ras_in.vsync;
            odd_line_d1       <= ras_in.odd_line;
            ras_out.in_window <= in_window_d1;
            ras_out.blank     <= blank_d1;
            ras_out.hsync     <= hsync_d1;
            ras_out.vsync     <= vsync_d1;
            ras_out.odd_line  <= odd_line_d1;
        end
    end

endmodule

/* hw/pixel_store.sv */
// ------------------------------------------------
// Frame memory: one write port addressed by pixel
// coordinate and one registered read port for the raster
// ------------------------------------------------

`timescale 1ns/1ns

module pixel_store import frame_pkg::*; (
    input  logic     clk_vga,
    input  logic     px_valid,
    input  logic     px_ready,
    input  coord_t   px_x,
    input  coord_t   px_y,
    input  pixel_t   px_data,
    input  fb_addr_t rd_addr,
    output pixel_t   rd_data
);

    pixel_t   mem [FB_DEPTH];   // Row-major image, one entry per stored pixel

    logic     wr_accept;        // Handshake completes this cycle
    logic     wr_in_range;
    fb_addr_t wr_addr;

    // ------------------------------------------------
    // Write side
    // ------------------------------------------------
    assign wr_accept   = px_valid && px_ready;
    // Off-image writes still complete the handshake but leave memory untouched
    assign wr_in_range = (px_x < coord_t'(FRAME_W)) && (px_y < coord_t'(FRAME_H));
    assign wr_addr     = fb_addr_t'(px_y * FRAME_W + px_x);

    always_ff @(posedge clk_vga) begin
        if (wr_accept && wr_in_range) begin
            mem[wr_addr] <= px_data;
        end
    end

    // ------------------------------------------------
    // Read side
    // ------------------------------------------------
    // One cycle of latency, the execute stage delays its controls to match
    always_ff @(posedge clk_vga) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* hw/raster_decode.sv */
// ------------------------------------------------
// Screen counters for 640x480@60 with sync, blank and
// window decode; also holds the per-frame rotation and
// opens the pixel write port during vertical blanking
// ------------------------------------------------

`timescale 1ns/1ns

module raster_decode import vga_timing_pkg::*, frame_pkg::*; (
    input  logic    clk_vga,
    input  logic    reset,
    input  rotate_e rotate,     // Requested rotation, takes effect at the next frame
    output logic    px_ready,   // Writes accepted only while the screen is in vblank
    raster_if.source ras
);

    hcount_t hcount;            // Pixel within the line
    vcount_t vcount;            // Line within the frame
    rotate_e rot_lat;           // Rotation for the frame being scanned

    logic    line_end;
    logic    frame_end;
    logic    landscape;
    hcount_t win_x0;
    hcount_t win_w;
    vcount_t win_y0;
    vcount_t win_h;
    hcount_t rel_x;
    vcount_t rel_y;
    logic    in_win;

    // ------------------------------------------------
    // Counters and rotation latch
    // ------------------------------------------------
    assign line_end  = (hcount == hcount_t'(H_TOTAL - 1));
    assign frame_end = line_end && (vcount == vcount_t'(V_TOTAL - 1));

    always_ff @(posedge clk_vga) begin
        if (reset) begin
            hcount  <= '0;
            vcount  <= '0;
            rot_lat <= ROT_0;               // First frame is always unrotated
        end else begin
            if (line_end) begin
                hcount <= '0;
                vcount <= frame_end ? '0 : vcount + 1'b1;
            end else begin
                hcount <= hcount + 1'b1;
            end
            // Sampling only at the wrap keeps one orientation for a whole frame
            if (frame_end) begin
                rot_lat <= rotate;
            end
        end
    end

    // Line counter at or past the visible area means nothing is being read from memory
    assign px_ready = (vcount >= vcount_t'(V_ACTIVE));

    // ------------------------------------------------
    // Window placement
    // ------------------------------------------------
    // A quarter turn swaps the image width and height on screen
    assign landscape = (rot_lat == ROT_0) || (rot_lat == ROT_180);
    assign win_x0    = landscape ? hcount_t'(WIN_X0_LAND) : hcount_t'(WIN_X0_PORT);
    assign win_y0    = landscape ? vcount_t'(WIN_Y0_LAND) : vcount_t'(WIN_Y0_PORT);
    assign win_w     = landscape ? hcount_t'(WIN_W_LAND)  : hcount_t'(WIN_W_PORT);
    assign win_h     = landscape ? vcount_t'(WIN_H_LAND)  : vcount_t'(WIN_H_PORT);

    // Offsets wrap when left of or above the window, the lower bound checks catch that
    assign rel_x  = hcount - win_x0;
    assign rel_y  = vcount - win_y0;
    assign in_win = (hcount >= win_x0) && (rel_x < win_w) &&
                    (vcount >= win_y0) && (rel_y < win_h);

    // ------------------------------------------------
    // Registered raster outputs
    // ------------------------------------------------
    always_ff @(posedge clk_vga) begin
        if (reset) begin
            ras.in_window <= 1'b0;
            ras.rot       <= ROT_0;
            ras.blank     <= 1'b1;
            ras.hsync     <= 1'b1;          // Sync lines idle high
            ras.vsync     <= 1'b1;
            ras.odd_line  <= 1'b0;
        end else begin
            ras.in_window <= in_win;
            ras.rot       <= rot_lat;
            ras.blank     <= (hcount >= hcount_t'(H_ACTIVE)) || (vcount >= vcount_t'(V_ACTIVE));
            ras.hsync     <= !((hcount >= hcount_t'(H_SYNC_START)) &&
                               (hcount <  hcount_t'(H_SYNC_END)));
            ras.vsync     <= !((vcount >= vcount_t'(V_SYNC_START)) &&
                               (vcount <  vcount_t'(V_SYNC_END)));
            ras.odd_line  <= vcount[0];
        end
    end

    // Outside the window the coordinate is parked at 0 so every read stays in range
    always_ff @(posedge clk_vga) begin
        ras.win_u <= in_win ? coord_t'(rel_x / hcount_t'(SCALE)) : '0;
        ras.win_v <= in_win ? coord_t'(rel_y / vcount_t'(SCALE)) : '0;
    end

endmodule

/* hw/raster_if.sv */
// ------------------------------------------------
// Raster position and video controls passed down the
// output pipeline, one screen position per clock
// ------------------------------------------------

`timescale 1ns/1ns

interface raster_if import frame_pkg::*; ();

    coord_t  win_u;      // Window column in image units, already divided by SCALE
    coord_t  win_v;      // Window row in image units
    logic    in_window;  // Position lies inside the scaled image
    rotate_e rot;        // Rotation in force for this frame
    logic    blank;      // High outside the 640x480 visible area
    logic    hsync;      // Negative pulse
    logic    vsync;      // Negative pulse
    logic    odd_line;   // Low bit of the line counter

    // Producer of a fresh raster position
    modport source (
        output win_u, win_v, in_window, rot,
        output blank, hsync, vsync, odd_line
    );

    // Stage that consumes the full position to build a read address
    modport stage (
        input win_u, win_v, in_window, rot,
        input blank, hsync, vsync, odd_line
    );

    // Last stage only needs the video controls
    modport sink (
        input in_window, blank, hsync, vsync, odd_line
    );

endinterface

/* hw/vga_timing_pkg.sv */
// ------------------------------------------------
// Raster timing for the fixed 640x480@60 output mode
// Import into any block that counts screen positions or
// decodes sync and blank from those counts
// ------------------------------------------------

package vga_timing_pkg;

    // ------------------------------------------------
    // Horizontal modeline, in pixel clocks
    // ------------------------------------------------
    localparam int H_ACTIVE     = 640;  // Visible pixels per line
    localparam int H_SYNC_START = 656;  // First pixel of the hsync pulse
    localparam int H_SYNC_END   = 752;  // First pixel after the hsync pulse
    localparam int H_TOTAL      = 800;  // Whole line including blanking

    // ------------------------------------------------
    // Vertical modeline, in lines
    // ------------------------------------------------
    localparam int V_ACTIVE     = 480;  // Visible lines per frame
    localparam int V_SYNC_START = 490;  // First line of the vsync pulse
    localparam int V_SYNC_END   = 492;  // First line after the vsync pulse
    localparam int V_TOTAL      = 525;  // Whole frame including blanking

    // Screen counters, wide enough for every position of the 800x525 frame
    typedef logic [10:0] hcount_t;
    typedef logic [10:0] vcount_t;

endpackage

/* hw/video_result.sv */
// ------------------------------------------------
// Output register stage: drives the pins from the aligned
// raster controls and forces black outside the image
// ------------------------------------------------

`timescale 1ns/1ns

module video_result import frame_pkg::*; (
    input  logic   clk_vga,
    input  logic   reset,
    raster_if.sink ras,
    input  pixel_t rd_data,         // Memory data for the position on ras
    output pixel_t rgb_out,
    output logic   hsync_out,
    output logic   vsync_out,
    output logic   blank_out,
    output logic   odd_line_out
);

    logic show_pixel;               // Visible and inside the window

    assign show_pixel = ras.in_window && !ras.blank;

    always_ff @(posedge clk_vga) begin
        if (reset) begin
            rgb_out      <= '0;
            hsync_out    <= 1'b1;       // Inactive sync level
            vsync_out    <= 1'b1;
            blank_out    <= 1'b1;
            odd_line_out <= 1'b0;
        end else begin
            rgb_out      <= show_pixel ? rd_data : '0;  // Border and blanking stay black
            hsync_out    <= ras.hsync;
            vsync_out    <= ras.vsync;
            blank_out    <= ras.blank;
            odd_line_out <= ras.odd_line;
        end
    end

endmodule
